// ==== hw/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int SHAMT_W    = $clog2(XLEN);
    localparam int DIV_CYCLES = 33;                 // Stall length of one divide
    localparam int DIV_ITERS  = DIV_CYCLES - 1;     // RUN cycles after the start cycle
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI                                         // Passes the immediate
    } alu_op_e;

    // Lane B write data source in MEM
    typedef enum logic [2:0] {
        ALU, MUL_LO, MUL_HI, DIV_QUO, DIV_REM
    } wb_sel_e;

    typedef enum logic [1:0] {
        IDLE, RUN, DONE
    } div_state_e;

    typedef struct packed {
        logic              rf_we;
        logic [REG_AW-1:0] waddr;
        logic [REG_AW-1:0] raddr1;
        logic [REG_AW-1:0] raddr2;
        logic [XLEN-1:0]   rdata1;                  // Register file values, not yet forwarded
        logic [XLEN-1:0]   rdata2;
        logic [XLEN-1:0]   imm;
        logic              src2_imm;
        alu_op_e           alu_op;
    } lane_issue_t;

    typedef struct packed {
        wb_sel_e wb_sel;
        logic    is_signed;                         // Mul and div only
    } lane_b_ext_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } wb_t;

    typedef struct packed {
        logic [2*XLEN-1:0] pp_lo;                   // x times low half of y
        logic [2*XLEN-1:0] pp_hi;                   // x times high half of y, shifted
    } mul_part_t;

endpackage

// ==== hw/pipe_ctrl.sv ====
`timescale 1ns/100ps

module pipe_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ex_div_req,
    input  exec_pkg::div_state_e div_state,
    output logic                 div_start,
    output logic                 stall,
    output logic                 ex_advance
);
    import exec_pkg::*;

    logic started;                                  // Divider already launched for this EX pair

    assign div_start  = ex_div_req & ~started;
    assign stall      = ex_div_req & (div_state != DONE);   // Drops in the DONE cycle
    assign ex_advance = ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (ex_advance) begin
            started <= 1'b0;                        // Pair leaves EX
        end else if (div_start) begin
            started <= 1'b1;
        end
    end

    // Stall only while a division is launching or running
    stall_needs_divider: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |-> ((div_state == RUN) || (div_state == IDLE && div_start))
    ) else $error("pipe_ctrl: stall without an active division");

    // Started flag keeps the divider from relaunching
    no_restart_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        (div_state == RUN) |-> !div_start
    ) else $error("pipe_ctrl: div_start while divider is running");

endmodule

// ==== hw/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
    input  exec_pkg::lane_issue_t     issue_a,
    input  exec_pkg::lane_issue_t     issue_b,
    input  exec_pkg::wb_t             mem_wb_a,
    input  exec_pkg::wb_t             mem_wb_b,
    input  exec_pkg::wb_t             wb_a,
    input  exec_pkg::wb_t             wb_b,
    output logic [exec_pkg::XLEN-1:0] a1,
    output logic [exec_pkg::XLEN-1:0] a2,
    output logic [exec_pkg::XLEN-1:0] b1,
    output logic [exec_pkg::XLEN-1:0] b2
);
    import exec_pkg::*;

    function automatic logic hit(input wb_t src, input logic [REG_AW-1:0] addr);
        return src.we && (src.waddr == addr);
    endfunction

    // Youngest producer first, lane B before lane A within a stage
    function automatic logic [XLEN-1:0] pick(input logic [REG_AW-1:0] addr,
                                             input logic [XLEN-1:0]   rf_val);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = rf_val;                           // r0 never forwarded
        end else if (hit(mem_wb_b, addr)) begin
            val = mem_wb_b.wdata;
        end else if (hit(mem_wb_a, addr)) begin
            val = mem_wb_a.wdata;
        end else if (hit(wb_b, addr)) begin
            val = wb_b.wdata;
        end else if (hit(wb_a, addr)) begin
            val = wb_a.wdata;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        a1 = pick(issue_a.raddr1, issue_a.rdata1);
        a2 = pick(issue_a.raddr2, issue_a.rdata2);
        b1 = pick(issue_b.raddr1, issue_b.rdata1);
        b2 = pick(issue_b.raddr2, issue_b.rdata2);
    end

endmodule

// ==== hw/alu_lane.sv ====
`timescale 1ns/100ps

module alu_lane (
    input  logic [exec_pkg::XLEN-1:0] op1,
    input  logic [exec_pkg::XLEN-1:0] op2_reg,
    input  logic [exec_pkg::XLEN-1:0] imm,
    input  logic                      src2_imm,
    input  exec_pkg::alu_op_e         alu_op,
    output logic [exec_pkg::XLEN-1:0] result
);
    import exec_pkg::*;

    logic [XLEN-1:0]    op2;
    logic [SHAMT_W-1:0] shamt;

    assign op2   = src2_imm ? imm : op2_reg;
    assign shamt = op2[SHAMT_W-1:0];                // Low five bits only

    always_comb begin
        case (alu_op)
            ADD:     result = op1 + op2;
            SUB:     result = op1 - op2;
            AND:     result = op1 & op2;
            OR:      result = op1 | op2;
            XOR:     result = op1 ^ op2;
            SLL:     result = op1 << shamt;
            SRL:     result = op1 >> shamt;
            SRA:     result = $signed(op1) >>> shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            SLTU:    result = {{(XLEN-1){1'b0}}, op1 < op2};
            LUI:     result = imm;
            default: result = '0;
        endcase
    end

    // Upstream decode must only hand over defined opcodes
    always_comb begin
        op_defined: assert (alu_op <= LUI)
            else $error("alu_lane: undefined alu_op %0d", alu_op);
    end

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit (
    input  logic [exec_pkg::XLEN-1:0]   x,
    input  logic [exec_pkg::XLEN-1:0]   y,
    input  logic                        is_signed,
    input  exec_pkg::mul_part_t         mem_part,
    output exec_pkg::mul_part_t         ex_part,
    output logic [2*exec_pkg::XLEN-1:0] mem_product
);
    import exec_pkg::*;

    localparam int HALF = XLEN / 2;

    logic signed [XLEN:0] xs;                       // x with one extension bit
    logic signed [HALF:0] y_lo;                     // Low half, always non-negative
    logic signed [HALF:0] y_hi;                     // High half carries the sign of y

    assign xs   = {is_signed & x[XLEN-1], x};
    assign y_lo = {1'b0, y[HALF-1:0]};
    assign y_hi = {is_signed & y[XLEN-1], y[XLEN-1:HALF]};

    // 33x17 partial products in EX, sign-extended to 64 bits
    assign ex_part.pp_lo = xs * y_lo;
    assign ex_part.pp_hi = (xs * y_hi) << HALF;

    // Low 64 bits of the MEM sum form the full product
    assign mem_product = mem_part.pp_lo + mem_part.pp_hi;

endmodule

// ==== hw/div_unit.sv ====
`timescale 1ns/100ps

module div_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [exec_pkg::XLEN-1:0] x,
    input  logic [exec_pkg::XLEN-1:0] y,
    input  logic                      is_signed,
    output exec_pkg::div_state_e      state,
    output logic [exec_pkg::XLEN-1:0] quotient,
    output logic [exec_pkg::XLEN-1:0] remainder
);
    import exec_pkg::*;

    logic [DIV_CNT_W-1:0] cnt;
    logic [XLEN-1:0]      quo;                      // Dividend shifts out, quotient bits in
    logic [XLEN-1:0]      rem;
    logic [XLEN-1:0]      dvs;                      // Divisor magnitude
    logic                 neg_q;
    logic                 neg_r;
    logic                 x_neg;
    logic                 y_neg;
    logic [XLEN:0]        rem_shift;
    logic [XLEN:0]        rem_diff;
    logic                 fits;

    assign x_neg     = is_signed & x[XLEN-1];
    assign y_neg     = is_signed & y[XLEN-1];
    assign rem_shift = {rem, quo[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs};
    assign fits      = rem_shift >= {1'b0, dvs};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        cnt   <= '0;
                    end
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_CNT_W'(DIV_ITERS - 1)) begin
                        state <= DONE;              // Last quotient bit this cycle
                    end
                end
                DONE:    state <= IDLE;             // Results held for one cycle
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            quo   <= x_neg ? -x : x;
            dvs   <= y_neg ? -y : y;
            rem   <= '0;
            neg_q <= (x_neg ^ y_neg) & (|y);        // Zero divisor keeps all ones
            neg_r <= x_neg;                         // Remainder follows the dividend
        end else if (state == RUN) begin
            rem <= fits ? rem_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
            quo <= {quo[XLEN-2:0], fits};
        end
    end

    // Sign fix on the magnitudes
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;

endmodule

// ==== hw/stage_regs.sv ====
`timescale 1ns/100ps

module stage_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ex_advance,
    input  exec_pkg::lane_issue_t       issue_a,
    input  exec_pkg::lane_issue_t       issue_b,
    input  exec_pkg::lane_b_ext_t       issue_b_ext,
    input  logic [exec_pkg::XLEN-1:0]   alu_res_a,
    input  logic [exec_pkg::XLEN-1:0]   alu_res_b,
    input  exec_pkg::mul_part_t         ex_part,
    input  logic [2*exec_pkg::XLEN-1:0] mem_product,
    input  logic [exec_pkg::XLEN-1:0]   quotient,
    input  logic [exec_pkg::XLEN-1:0]   remainder,
    output exec_pkg::wb_t               mem_wb_a,
    output exec_pkg::wb_t               mem_wb_b,
    output exec_pkg::mul_part_t         mem_part,
    output exec_pkg::wb_t               wb_a,
    output exec_pkg::wb_t               wb_b
);
    import exec_pkg::*;

    logic [1:0]        mem_we;                      // {B, A}
    logic              ex_fresh;                    // EX pair arrived on the last edge
    logic [REG_AW-1:0] mem_waddr_a;
    logic [REG_AW-1:0] mem_waddr_b;
    wb_sel_e           mem_wb_sel;
    logic [XLEN-1:0]   mem_alu_a;
    logic [XLEN-1:0]   mem_alu_b;
    logic [XLEN-1:0]   mem_quo;
    logic [XLEN-1:0]   mem_rem;
    logic [XLEN-1:0]   mem_wdata_b;
    logic [1:0]        wb_we;
    logic [REG_AW-1:0] wb_waddr_a;
    logic [REG_AW-1:0] wb_waddr_b;
    logic [XLEN-1:0]   wb_wdata_a;
    logic [XLEN-1:0]   wb_wdata_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_we   <= '0;
            wb_we    <= '0;
            ex_fresh <= 1'b1;
        end else begin
            mem_we   <= {issue_b.rf_we, issue_a.rf_we} & {2{ex_advance}};  // Bubble on stall
            wb_we    <= mem_we;                     // WB keeps draining
            ex_fresh <= ex_advance;
        end
    end

    always_ff @(posedge clk) begin
        // ALU results taken while MEM and WB still feed the stalled pair's operands
        if (ex_fresh) begin
            mem_alu_a <= alu_res_a;
            mem_alu_b <= alu_res_b;
        end
        if (ex_advance) begin
            mem_waddr_a <= issue_a.waddr;
            mem_waddr_b <= issue_b.waddr;
            mem_wb_sel  <= issue_b_ext.wb_sel;
            mem_part    <= ex_part;
            mem_quo     <= quotient;
            mem_rem     <= remainder;
        end
        wb_waddr_a <= mem_waddr_a;
        wb_waddr_b <= mem_waddr_b;
        wb_wdata_a <= mem_alu_a;
        wb_wdata_b <= mem_wdata_b;
    end

    // Lane B result select in MEM
    always_comb begin
        case (mem_wb_sel)
            MUL_LO:  mem_wdata_b = mem_product[XLEN-1:0];
            MUL_HI:  mem_wdata_b = mem_product[2*XLEN-1:XLEN];
            DIV_QUO: mem_wdata_b = mem_quo;
            DIV_REM: mem_wdata_b = mem_rem;
            default: mem_wdata_b = mem_alu_b;
        endcase
    end

    assign mem_wb_a = '{we: mem_we[0], waddr: mem_waddr_a, wdata: mem_alu_a};
    assign mem_wb_b = '{we: mem_we[1], waddr: mem_waddr_b, wdata: mem_wdata_b};
    assign wb_a     = '{we: wb_we[0], waddr: wb_waddr_a, wdata: wb_wdata_a};
    assign wb_b     = '{we: wb_we[1], waddr: wb_waddr_b, wdata: wb_wdata_b};

endmodule

// ==== hw/exec_top.sv ====
`timescale 1ns/100ps

module exec_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  exec_pkg::lane_issue_t issue_a,
    input  exec_pkg::lane_issue_t issue_b,
    input  exec_pkg::lane_b_ext_t issue_b_ext,
    output logic                  stall,
    output exec_pkg::wb_t         wb_a,
    output exec_pkg::wb_t         wb_b
);
    import exec_pkg::*;

    logic            ex_advance;
    logic            div_start;
    div_state_e      div_state;
    logic [XLEN-1:0] a1;
    logic [XLEN-1:0] a2;
    logic [XLEN-1:0] b1;
    logic [XLEN-1:0] b2;
    logic [XLEN-1:0] alu_res_a;
    logic [XLEN-1:0] alu_res_b;
    mul_part_t       ex_part;
    mul_part_t       mem_part;
    logic [2*XLEN-1:0] mem_product;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    wb_t             mem_wb_a;
    wb_t             mem_wb_b;

    pipe_ctrl ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_div_req (issue_b.rf_we && (issue_b_ext.wb_sel inside {DIV_QUO, DIV_REM})),
        .div_state  (div_state),
        .div_start  (div_start),
        .stall      (stall),
        .ex_advance (ex_advance)
    );

    operand_forward fwd0 (
        .issue_a  (issue_a),
        .issue_b  (issue_b),
        .mem_wb_a (mem_wb_a),
        .mem_wb_b (mem_wb_b),
        .wb_a     (wb_a),
        .wb_b     (wb_b),
        .a1       (a1),
        .a2       (a2),
        .b1       (b1),
        .b2       (b2)
    );

    alu_lane alu_a (
        .op1      (a1),
        .op2_reg  (a2),
        .imm      (issue_a.imm),
        .src2_imm (issue_a.src2_imm),
        .alu_op   (issue_a.alu_op),
        .result   (alu_res_a)
    );

    alu_lane alu_b (
        .op1      (b1),
        .op2_reg  (b2),
        .imm      (issue_b.imm),
        .src2_imm (issue_b.src2_imm),
        .alu_op   (issue_b.alu_op),
        .result   (alu_res_b)
    );

    mul_unit mul0 (
        .x           (b1),
        .y           (b2),
        .is_signed   (issue_b_ext.is_signed),
        .mem_part    (mem_part),
        .ex_part     (ex_part),
        .mem_product (mem_product)
    );

    div_unit div0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .x         (b1),
        .y         (b2),
        .is_signed (issue_b_ext.is_signed),
        .state     (div_state),
        .quotient  (quotient),
        .remainder (remainder)
    );

    stage_regs regs0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_advance  (ex_advance),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_b_ext (issue_b_ext),
        .alu_res_a   (alu_res_a),
        .alu_res_b   (alu_res_b),
        .ex_part     (ex_part),
        .mem_product (mem_product),
        .quotient    (quotient),
        .remainder   (remainder),
        .mem_wb_a    (mem_wb_a),
        .mem_wb_b    (mem_wb_b),
        .mem_part    (mem_part),
        .wb_a        (wb_a),
        .wb_b        (wb_b)
    );

endmodule

// ==== verif/exec_tb.sv ====
`timescale 1ns/100ps

module exec_tb;
    import exec_pkg::*;

    localparam int ROWS     = 30;
    localparam int ROW_W    = 22;                   // Words per pattern row
    localparam int LANE_B   = 9;
    localparam int EXT      = 18;
    localparam int EXP      = 20;
    localparam int WDOG_CYC = ROWS * (DIV_CYCLES + 4) + 20;

    logic        clk;
    logic        rst_n;
    lane_issue_t issue_a;
    lane_issue_t issue_b;
    lane_b_ext_t issue_b_ext;
    logic        stall;
    wb_t         wb_a;
    wb_t         wb_b;

    logic [31:0] pat [0:ROWS*ROW_W-1];
    wb_t         exp_q [$];                         // Expected writebacks in issue order
    int          due_q [$];
    int          neg_cyc    = 0;
    logic        stall_q    = 1'b0;                 // Stall seen in the last cycle
    int          stall_len  = 0;
    int          stall_runs = 0;
    int          div_rows   = 0;
    int          checks     = 0;
    int          errors     = 0;
    int          idx;

    exec_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_b_ext (issue_b_ext),
        .stall       (stall),
        .wb_a        (wb_a),
        .wb_b        (wb_b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic lane_issue_t lane_from(input int base);
        lane_issue_t l;
        l.rf_we    = pat[base][0];
        l.waddr    = pat[base+1][REG_AW-1:0];
        l.raddr1   = pat[base+2][REG_AW-1:0];
        l.raddr2   = pat[base+3][REG_AW-1:0];
        l.rdata1   = pat[base+4];
        l.rdata2   = pat[base+5];
        l.imm      = pat[base+6];
        l.src2_imm = pat[base+7][0];
        l.alu_op   = alu_op_e'(pat[base+8][3:0]);
        return l;
    endfunction

    task automatic drive_row(input int r);
        lane_b_ext_t ext;
        ext.wb_sel    = wb_sel_e'(pat[r*ROW_W+EXT][2:0]);
        ext.is_signed = pat[r*ROW_W+EXT+1][0];
        issue_a     <= lane_from(r * ROW_W);
        issue_b     <= lane_from(r * ROW_W + LANE_B);
        issue_b_ext <= ext;
    endtask

    task automatic queue_expected(input int base, input logic [31:0] wdata);
        wb_t e;
        if (pat[base][0]) begin
            e.we    = 1'b1;
            e.waddr = pat[base+1][REG_AW-1:0];
            e.wdata = wdata;
            exp_q.push_back(e);
            due_q.push_back(neg_cyc + 2);           // In WB after the next edge
        end
    endtask

    task automatic compare_wb(input string lane, input wb_t got);
        wb_t e;
        int  due;
        if (got.we) begin
            checks++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("lane %s wrote r%0d at %0t but no writeback was pending",
                         lane, got.waddr, $time);
            end else begin
                e   = exp_q.pop_front();
                due = due_q.pop_front();
                if (got.waddr !== e.waddr || got.wdata !== e.wdata) begin
                    errors++;
                    $display("error at %0t: lane %s wrote r%0d=%h, expected r%0d=%h",
                             $time, lane, got.waddr, got.wdata, e.waddr, e.wdata);
                end
                if (neg_cyc != due) begin
                    errors++;
                    $display("error at %0t: lane %s writeback in cycle %0d, expected %0d",
                             $time, lane, neg_cyc, due);
                end
            end
        end
    endtask

    // Outputs settle between edges
    always @(negedge clk) begin
        neg_cyc = neg_cyc + 1;
        stall_q = stall;
        if (rst_n) begin
            compare_wb("A", wb_a);
            compare_wb("B", wb_b);
            if (stall) begin
                stall_len++;
            end else if (stall_len != 0) begin
                stall_runs++;
                if (stall_len != DIV_CYCLES) begin
                    errors++;
                    $display("error at %0t: stall high for %0d cycles, expected %0d",
                             $time, stall_len, DIV_CYCLES);
                end
                stall_len = 0;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        issue_a     = '0;
        issue_b     = '0;
        issue_b_ext = '0;
        $readmemh("verif/exec_patterns.txt", pat);
        for (int r = 0; r < ROWS; r++) begin
            if (pat[r*ROW_W+LANE_B][0] && pat[r*ROW_W+EXT] inside {3, 4}) begin
                div_rows++;
            end
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if (stall || wb_a.we || wb_b.we) begin
            errors++;
            $display("error at %0t: stall or writeback active after reset", $time);
        end
        @(posedge clk);
        drive_row(0);
        idx = 0;
        while (idx < ROWS) begin
            @(posedge clk);
            if (!stall_q) begin                     // This edge took the pair
                queue_expected(idx * ROW_W, pat[idx*ROW_W+EXP]);
                queue_expected(idx * ROW_W + LANE_B, pat[idx*ROW_W+EXP+1]);
                idx++;
                if (idx < ROWS) begin
                    drive_row(idx);
                end else begin
                    issue_a     <= '0;
                    issue_b     <= '0;
                    issue_b_ext <= '0;
                end
            end
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);                  // Catch stray writebacks
        checks++;
        if (stall_runs != div_rows) begin
            errors++;
            $display("error at %0t: %0d stall periods, expected %0d",
                     $time, stall_runs, div_rows);
        end
        $display("exec_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WDOG_CYC);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verif/exec_patterns.txt ====
// Per lane: we waddr raddr1 raddr2 rdata1 rdata2 imm src2_imm alu_op (lane A, then lane B)
// Then: wb_sel is_signed | expected wdata lane A, expected wdata lane B (waddr from issue)
// ALU opcodes, both lanes, register and immediate operand 2
1 1 14 15 5 3 0 0 0           1 2 16 0 a 0 4 1 1                  0 0 8 6
1 3 17 0 f0f0 0 ff 1 2        1 4 18 19 f00 f0 0 0 3              0 0 f0 ff0
1 5 1a 0 ff 0 f 1 4           1 6 1b 1c 1 24 0 0 5                0 0 f0 10
1 7 1d 0 80000000 0 4 1 6     1 8 1d 1e 80000000 28 0 0 7         0 0 8000000 ff800000
1 9 14 0 ffffffff 0 1 1 8     1 a 15 16 ffffffff 1 0 0 9          0 0 1 0
1 b 0 0 0 0 12345000 1 a      1 c 17 18 5 fffffffe 0 0 8          0 0 12345000 0
1 d 19 1a 10 20 0 0 1         1 e 1b 0 7fffffff 0 1 1 0           0 0 fffffff0 80000000
1 f 1c 1d 1 100 0 0 3         1 10 1e 1f ff00 ff0 0 0 2           0 0 101 f00
1 11 14 0 3 0 2 1 5           1 12 15 0 aaaa 0 ffff 1 4           0 0 c 5555
1 13 16 17 ffffff00 4 0 0 7   1 1 18 0 f0 0 4 1 6                 0 0 fffffff0 f
1 2 19 0 1 0 2 1 9            1 3 0 0 0 0 abcde000 1 a            0 0 1 abcde000
// Forwarding from MEM and WB, same-address writes, r0
1 5 3 2 0 0 0 0 0             1 6 1 0 77 0 10 1 0                 0 0 abcde001 1f
1 7 5 0 0 0 1 1 0             1 7 6 0 0 0 2 1 0                   0 0 abcde002 21
1 8 7 0 55 0 0 1 0            1 0 6 0 0 0 1000 1 0                0 0 21 101f
1 a 0 7 0 3 0 0 0             1 b 0 0 0 0 5 1 3                   0 0 21 5
// Multiply, low and high word, signed and unsigned
1 c 14 15 2 3 0 0 0           1 d 16 17 12345 10000 0 0 0         1 0 5 23450000
1 e d 0 9 0 0 1 0             1 f 18 19 ffffffff ffffffff 0 0 0   2 0 23450000 fffffffe
1 11 f 0 0 0 e 1 1            1 10 18 19 ffffffff ffffffff 0 0 0  2 1 fffffff0 0
0 0 0 0 0 0 0 0 0             1 12 1a 1b fffffffd 7 0 0 0         1 1 0 ffffffeb
1 1 12 10 0 0 0 0 0           1 13 1c 1d fffffffd 40000000 0 0 0  2 1 ffffffeb ffffffff
// Divide, remainder, divide by zero, dependent pairs around the stall
1 2 14 0 100 0 1 1 0          1 3 0 0 0 0 7 1 a                   0 0 101 7
1 5 2 0 0 0 0 1 0             1 4 15 3 64 0 0 0 0                 3 0 101 e
1 6 4 0 0 0 1 1 0             1 7 15 17 64 7 0 0 0                4 0 f 2
1 9 7 6 0 0 0 0 0             1 8 18 19 ffffff9c 7 0 0 0          3 1 11 fffffff2
0 0 0 0 0 0 0 0 0             1 a 18 19 ffffff9c 7 0 0 0          4 1 0 fffffffe
1 c a 0 0 0 2 1 0             1 b 1a 1b 55 0 0 0 0                3 0 0 ffffffff
1 e b 0 0 0 1 1 0             1 d 1a 1b 55 0 0 0 0                4 0 0 55
0 0 0 0 0 0 0 0 0             1 f 1c 1d fffffffb 0 0 0 0          3 1 0 ffffffff
0 0 0 0 0 0 0 0 0             1 10 1c 1d fffffffb 0 0 0 0         4 1 0 fffffffb
1 11 10 f 0 ffffffff 0 0 1    1 12 0 0 0 0 3 1 0                  0 0 fffffffc 3

// ==== verilog.f ====
hw/exec_pkg.sv
hw/pipe_ctrl.sv
hw/operand_forward.sv
hw/alu_lane.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/stage_regs.sv
hw/exec_top.sv
verif/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run from the project root
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module exec_tb -o exec_sim \
    && ./obj_dir/exec_sim | grep -F "*** PASSED ***" \
    || { echo "simulation did not pass"; exit 1; }
